/* verilog/pet_bus_config.svh */
//**************************************************************************
// shared constants of the bus timing core
// RAM is byte wide, addresses above the RAM range are rejected by APB
// slot count is fixed at 8 by the 3-bit slot type in the package
//**************************************************************************
`ifndef PET_BUS_CONFIG_SVH
`define PET_BUS_CONFIG_SVH

`default_nettype none

// RAM address width, 1024 bytes
`define PET_RAM_AW 10
// screen memory window
`define PET_VRAM_BASE 10'h200
`define PET_VRAM_CHARS 64
// host bus address width
`define PET_APB_AW 16
// bus slots per frame
`define PET_SLOTS 8

`default_nettype wire

`endif

/* verilog/pet_bus_pkg.sv */
//**************************************************************************
// types shared by the bus timing core
// slot_e encoding is the slot number itself, 3 bits, 8 slots per frame
// struct widths follow the RAM address width from the config header
//**************************************************************************
`include "pet_bus_config.svh"

`default_nettype none

package pet_bus_pkg;

    // owner of each bus slot, value equals slot number
    typedef enum logic [2:0] {
        SLOT_HOST      = 3'd0,
        SLOT_VIDEO     = 3'd1,
        SLOT_IDLE2     = 3'd2,
        SLOT_IDLE3     = 3'd3,
        SLOT_IDLE4     = 3'd4,
        SLOT_IDLE5     = 3'd5,
        SLOT_CPU_SETUP = 3'd6,
        SLOT_CPU       = 3'd7
    } slot_e;

    // host port FSM
    typedef enum logic [1:0] {
        IDLE,
        WAIT_SLOT,
        DONE
    } apb_state_e;

    // one RAM access, 20 bits
    typedef struct packed {
        logic                   valid;
        logic                   write;
        logic [`PET_RAM_AW-1:0] addr;
        logic [7:0]             wdata;
    } bus_req_t;

    // one screen byte toward the video side, 19 bits
    typedef struct packed {
        logic                   valid;
        logic [`PET_RAM_AW-1:0] addr;
        logic [7:0]             data;
    } video_out_t;

endpackage

`default_nettype wire

/* verilog/bus_timing.sv */
//**************************************************************************
// frame of 8 slots, 2 clocks each, 16 clocks per frame
// strobe is high in the second clock of every slot
// all outputs are registered, frame restarts in slot 0 after reset
//**************************************************************************
`include "pet_bus_config.svh"

`default_nettype none

module bus_timing
    import pet_bus_pkg::*;
(
    input  wire logic  clk16_i,
    input  wire logic  rst_n_i,
    output slot_e      slot_o,
    output logic       strobe_o,
    output logic       cpu_be_o,
    output logic       cpu_clk_o
);

    // phase 0 = setup half of a slot, phase 1 = strobe half
    logic  phase_q;
    logic  phase_d;
    slot_e slot_q;
    slot_e slot_d;
    logic  cpu_be_q;
    logic  cpu_clk_q;

    // next slot and phase
    always_comb begin
        phase_d = ~phase_q;
        slot_d  = slot_q;
        // slot only moves after its strobe half
        if (phase_q) begin
            if (slot_q == slot_e'(`PET_SLOTS - 1)) begin
                slot_d = SLOT_HOST;
            end else begin
                slot_d = slot_e'(slot_q + 3'd1);
            end
        end
    end

    always_ff @(posedge clk16_i) begin
        if (!rst_n_i) begin
            phase_q   <= 1'b0;
            slot_q    <= SLOT_HOST;
            cpu_be_q  <= 1'b0;
            cpu_clk_q <= 1'b0;
        end else begin
            phase_q   <= phase_d;
            slot_q    <= slot_d;
            // bus enable covers the setup slot and the cpu slot
            cpu_be_q  <= (slot_d == SLOT_CPU_SETUP) || (slot_d == SLOT_CPU);
            // cpu clock = strobe gated by cpu slot, decoded one clock early
            cpu_clk_q <= (slot_d == SLOT_CPU) && phase_d;
        end
    end

    // strobe sits centered in the slot, enables stable around it
    assign strobe_o  = phase_q;
    assign slot_o    = slot_q;
    assign cpu_be_o  = cpu_be_q;
    assign cpu_clk_o = cpu_clk_q;

endmodule

`default_nettype wire

/* verilog/host_apb_port.sv */
//**************************************************************************
// APB3 slave for host access to the shared RAM
// one request outstanding, served in the next slot 0 access
// addresses at or above the RAM size end with pslverr in the first access
// cycle and never reach the RAM
//**************************************************************************
`include "pet_bus_config.svh"

`default_nettype none

module host_apb_port
    import pet_bus_pkg::*;
(
    input  wire logic                   clk16_i,
    input  wire logic                   rst_n_i,
    input  wire logic                   psel_i,
    input  wire logic                   penable_i,
    input  wire logic                   pwrite_i,
    input  wire logic [`PET_APB_AW-1:0] paddr_i,
    input  wire logic [7:0]             pwdata_i,
    output logic      [7:0]             prdata_o,
    output logic                        pready_o,
    output logic                        pslverr_o,
    output bus_req_t                    host_req_o,
    input  wire logic                   host_ack_i,
    input  wire logic [7:0]             host_rdata_i
);

    apb_state_e             state_q;
    logic                   req_valid_q;
    logic                   pslverr_q;
    logic                   req_write_q;
    logic [`PET_RAM_AW-1:0] req_addr_q;
    logic [7:0]             req_wdata_q;
    logic [7:0]             prdata_q;
    logic                   setup;
    logic                   out_of_range;

    // setup phase of a new transfer
    assign setup        = psel_i && !penable_i;
    // any bit above the RAM range set
    assign out_of_range = |paddr_i[`PET_APB_AW-1:`PET_RAM_AW];

    // control FSM
    always_ff @(posedge clk16_i) begin
        if (!rst_n_i) begin
            state_q     <= IDLE;
            req_valid_q <= 1'b0;
            pslverr_q   <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (setup) begin
                        if (out_of_range) begin
                            // error ends in the first access cycle
                            pslverr_q <= 1'b1;
                            state_q   <= DONE;
                        end else begin
                            req_valid_q <= 1'b1;
                            state_q     <= WAIT_SLOT;
                        end
                    end
                end
                WAIT_SLOT: begin
                    // ack comes with the slot 0 access
                    if (host_ack_i) begin
                        req_valid_q <= 1'b0;
                        state_q     <= DONE;
                    end
                end
                DONE: begin
                    // pready was high for this one cycle
                    pslverr_q <= 1'b0;
                    state_q   <= IDLE;
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // request payload, captured in setup phase
    always_ff @(posedge clk16_i) begin
        if (state_q == IDLE && setup) begin
            req_write_q <= pwrite_i;
            req_addr_q  <= paddr_i[`PET_RAM_AW-1:0];
            req_wdata_q <= pwdata_i;
        end
    end

    // read data, valid in the ack cycle
    always_ff @(posedge clk16_i) begin
        if (state_q == WAIT_SLOT && host_ack_i) begin
            prdata_q <= host_rdata_i;
        end
    end

    assign host_req_o = '{valid: req_valid_q, write: req_write_q,
                          addr: req_addr_q, wdata: req_wdata_q};
    assign pready_o   = (state_q == DONE);
    assign pslverr_o  = pslverr_q;
    assign prdata_o   = prdata_q;

endmodule

`default_nettype wire

/* verilog/bus_arbiter_ram.sv */
//**************************************************************************
// shared 1024 byte RAM, one access per slot at the end of the strobe
// host in slot 0, video in slot 1, cpu in slot 7, slots 2 to 6 idle
// read data toward host and video is combinational from the array
// cpu read data is registered at the slot 7 access
//**************************************************************************
`include "pet_bus_config.svh"

`default_nettype none

module bus_arbiter_ram
    import pet_bus_pkg::*;
(
    input  wire logic                   clk16_i,
    input  wire logic                   rst_n_i,
    input  wire slot_e                  slot_i,
    input  wire logic                   strobe_i,
    input  wire bus_req_t               host_req_i,
    output logic                        host_ack_o,
    output logic      [7:0]             host_rdata_o,
    input  wire logic [`PET_RAM_AW-1:0] video_addr_i,
    output logic                        video_ack_o,
    output logic      [7:0]             video_data_o,
    input  wire bus_req_t               cpu_req_i,
    output logic      [7:0]             cpu_rdata_o
);

    logic [7:0] mem [0:(1 << `PET_RAM_AW) - 1];

    // slot owner enables, only in the strobe half of a slot
    logic host_en;
    logic video_en;
    logic cpu_en;
    logic host_wr;
    logic cpu_wr;
    logic cpu_rd;
    logic [7:0] cpu_rdata_q;

    assign host_en  = strobe_i && (slot_i == SLOT_HOST);
    assign video_en = strobe_i && (slot_i == SLOT_VIDEO);
    assign cpu_en   = strobe_i && (slot_i == SLOT_CPU);

    // owner without a valid request leaves the RAM alone
    assign host_wr = host_en && host_req_i.valid && host_req_i.write;
    assign cpu_wr  = cpu_en && cpu_req_i.valid && cpu_req_i.write;
    assign cpu_rd  = cpu_en && cpu_req_i.valid && !cpu_req_i.write;

    // host ack only for a pending request
    assign host_ack_o   = host_en && host_req_i.valid;
    assign host_rdata_o = mem[host_req_i.addr];

    // video reads every frame, no request needed
    assign video_ack_o  = video_en;
    assign video_data_o = mem[video_addr_i];

    // RAM writes, at most one owner per slot
    always_ff @(posedge clk16_i) begin
        if (host_wr) begin
            mem[host_req_i.addr] <= host_req_i.wdata;
        end else if (cpu_wr) begin
            mem[cpu_req_i.addr] <= cpu_req_i.wdata;
        end
    end

    // cpu read data, updated at the slot 7 access edge
    always_ff @(posedge clk16_i) begin
        if (!rst_n_i) begin
            cpu_rdata_q <= 8'h00;
        end else if (cpu_rd) begin
            cpu_rdata_q <= mem[cpu_req_i.addr];
        end
    end

    assign cpu_rdata_o = cpu_rdata_q;

endmodule

`default_nettype wire

/* verilog/video_fetch.sv */
//**************************************************************************
// screen scanner, one character byte per frame from the screen window
// address wraps after the last screen byte back to the base
// output has no back-pressure, every valid byte must be taken
//**************************************************************************
`include "pet_bus_config.svh"

`default_nettype none

module video_fetch
    import pet_bus_pkg::*;
(
    input  wire logic                   clk16_i,
    input  wire logic                   rst_n_i,
    input  wire logic                   video_ack_i,
    input  wire logic [7:0]             video_data_i,
    output logic      [`PET_RAM_AW-1:0] video_addr_o,
    output video_out_t                  video_o
);

    localparam int OFS_W = $clog2(`PET_VRAM_CHARS);

    logic [OFS_W-1:0]       offset_q;
    logic                   valid_q;
    logic [`PET_RAM_AW-1:0] addr_q;
    logic [7:0]             data_q;

    // base plus offset into screen memory
    assign video_addr_o = `PET_VRAM_BASE + {{(`PET_RAM_AW - OFS_W){1'b0}}, offset_q};

    // offset and valid strobe
    always_ff @(posedge clk16_i) begin
        if (!rst_n_i) begin
            offset_q <= '0;
            valid_q  <= 1'b0;
        end else begin
            // one cycle pulse after each slot 1 access
            valid_q <= video_ack_i;
            if (video_ack_i) begin
                if (offset_q == OFS_W'(`PET_VRAM_CHARS - 1)) begin
                    offset_q <= '0;
                end else begin
                    offset_q <= offset_q + 1'b1;
                end
            end
        end
    end

    // byte and its address travel together
    always_ff @(posedge clk16_i) begin
        if (video_ack_i) begin
            addr_q <= video_addr_o;
            data_q <= video_data_i;
        end
    end

    assign video_o = '{valid: valid_q, addr: addr_q, data: data_q};

endmodule

`default_nettype wire

/* verilog/pet_bus_top.sv */
//**************************************************************************
// shared bus core, host APB port in, video bytes out, cpu port on slot 7
// cpu_req_i is sampled only at the slot 7 access, hold it across cpu_be_o
// video_o must be accepted in every valid cycle
//**************************************************************************
`include "pet_bus_config.svh"

`default_nettype none

module pet_bus_top
    import pet_bus_pkg::*;
(
    input  wire logic                   clk16_i,
    input  wire logic                   rst_n_i,
    // host APB
    input  wire logic                   psel_i,
    input  wire logic                   penable_i,
    input  wire logic                   pwrite_i,
    input  wire logic [`PET_APB_AW-1:0] paddr_i,
    input  wire logic [7:0]             pwdata_i,
    output logic      [7:0]             prdata_o,
    output logic                        pready_o,
    output logic                        pslverr_o,
    // cpu side
    input  wire bus_req_t               cpu_req_i,
    output logic      [7:0]             cpu_rdata_o,
    output logic                        cpu_be_o,
    output logic                        cpu_clk_o,
    // video side
    output video_out_t                  video_o
);

    slot_e                  slot;
    logic                   strobe;
    bus_req_t               host_req;
    logic                   host_ack;
    logic [7:0]             host_rdata;
    logic [`PET_RAM_AW-1:0] video_addr;
    logic                   video_ack;
    logic [7:0]             video_data;

    // slot sequencer
    bus_timing timing0 (
        .clk16_i   (clk16_i),
        .rst_n_i   (rst_n_i),
        .slot_o    (slot),
        .strobe_o  (strobe),
        .cpu_be_o  (cpu_be_o),
        .cpu_clk_o (cpu_clk_o)
    );

    // host side
    host_apb_port apb0 (
        .clk16_i      (clk16_i),
        .rst_n_i      (rst_n_i),
        .psel_i       (psel_i),
        .penable_i    (penable_i),
        .pwrite_i     (pwrite_i),
        .paddr_i      (paddr_i),
        .pwdata_i     (pwdata_i),
        .prdata_o     (prdata_o),
        .pready_o     (pready_o),
        .pslverr_o    (pslverr_o),
        .host_req_o   (host_req),
        .host_ack_i   (host_ack),
        .host_rdata_i (host_rdata)
    );

    // RAM and slot owner selection
    bus_arbiter_ram ram0 (
        .clk16_i      (clk16_i),
        .rst_n_i      (rst_n_i),
        .slot_i       (slot),
        .strobe_i     (strobe),
        .host_req_i   (host_req),
        .host_ack_o   (host_ack),
        .host_rdata_o (host_rdata),
        .video_addr_i (video_addr),
        .video_ack_o  (video_ack),
        .video_data_o (video_data),
        .cpu_req_i    (cpu_req_i),
        .cpu_rdata_o  (cpu_rdata_o)
    );

    // screen scan
    video_fetch video0 (
        .clk16_i      (clk16_i),
        .rst_n_i      (rst_n_i),
        .video_ack_i  (video_ack),
        .video_data_i (video_data),
        .video_addr_o (video_addr),
        .video_o      (video_o)
    );

endmodule

`default_nettype wire

/* bench/pet_bus_chk.sv */
//**************************************************************************
// slot timing checks, bound into every bus_timing instance
// checks are off while reset is low
//**************************************************************************
`default_nettype none

module pet_bus_chk
    import pet_bus_pkg::*;
(
    input wire logic  clk16_i,
    input wire logic  rst_n_i,
    input wire slot_e slot_i,
    input wire logic  strobe_i,
    input wire logic  cpu_be_i,
    input wire logic  cpu_clk_i
);

    // strobe toggles every clock once out of reset
    strobe_toggle: assert property (@(posedge clk16_i) disable iff (!rst_n_i)
        $past(rst_n_i) |-> (strobe_i != $past(strobe_i)))
        else $error("strobe did not toggle");

    // cpu clock only in the strobe half of slot 7
    cpu_clk_gate: assert property (@(posedge clk16_i) disable iff (!rst_n_i)
        cpu_clk_i |-> (slot_i == SLOT_CPU) && strobe_i)
        else $error("cpu clock outside the cpu strobe");

    // bus enable exactly over slots 6 and 7
    cpu_be_window: assert property (@(posedge clk16_i) disable iff (!rst_n_i)
        cpu_be_i == ((slot_i == SLOT_CPU_SETUP) || (slot_i == SLOT_CPU)))
        else $error("cpu bus enable outside slots 6 and 7");

endmodule

bind bus_timing pet_bus_chk chk0 (
    .clk16_i   (clk16_i),
    .rst_n_i   (rst_n_i),
    .slot_i    (slot_o),
    .strobe_i  (strobe_o),
    .cpu_be_i  (cpu_be_o),
    .cpu_clk_i (cpu_clk_o)
);

`default_nettype wire

/* bench/pet_bus_tb.sv */
//**************************************************************************
// random APB, cpu and video stimulus against a byte model of the RAM
// video data is only compared for bytes the bench has written
//**************************************************************************
`include "pet_bus_config.svh"

`default_nettype none

module pet_bus_tb
    import pet_bus_pkg::*;
();

    logic                   clk16_i;
    logic                   rst_n_i;
    logic                   psel_i;
    logic                   penable_i;
    logic                   pwrite_i;
    logic [`PET_APB_AW-1:0] paddr_i;
    logic [7:0]             pwdata_i;
    logic [7:0]             prdata_o;
    logic                   pready_o;
    logic                   pslverr_o;
    bus_req_t               cpu_req_i;
    logic [7:0]             cpu_rdata_o;
    logic                   cpu_be_o;
    logic                   cpu_clk_o;
    video_out_t             video_o;

    // reference RAM and which bytes hold known data
    logic [7:0] model [0:(1 << `PET_RAM_AW) - 1];
    logic       known [0:(1 << `PET_RAM_AW) - 1];
    int         err_count;
    int         video_errs;
    int         video_checked;
    int         cyc;
    logic [`PET_RAM_AW-1:0] exp_vaddr;

    pet_bus_top dut0 (
        .clk16_i     (clk16_i),
        .rst_n_i     (rst_n_i),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .paddr_i     (paddr_i),
        .pwdata_i    (pwdata_i),
        .prdata_o    (prdata_o),
        .pready_o    (pready_o),
        .pslverr_o   (pslverr_o),
        .cpu_req_i   (cpu_req_i),
        .cpu_rdata_o (cpu_rdata_o),
        .cpu_be_o    (cpu_be_o),
        .cpu_clk_o   (cpu_clk_o),
        .video_o     (video_o)
    );

    initial begin
        clk16_i = 1'b0;
        forever begin
            #10 clk16_i = ~clk16_i;
        end
    end

    // cycles since reset release, cycle 0 is frame start
    always @(posedge clk16_i) begin
        if (!rst_n_i) begin
            cyc <= 0;
        end else begin
            cyc <= cyc + 1;
        end
    end

    task automatic check_value(input string name, input logic [15:0] exp,
                               input logic [15:0] act);
        assert (act === exp) else begin
            $display("FAIL %s: expected %0h, actual %0h", name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_true(input string name, input logic cond, input string msg);
        assert (cond === 1'b1) else begin
            $display("%s: %s", name, msg);
            err_count++;
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("Verification failed");
        $finish;
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, err_count - errs_before);
        end
    endtask

    // one APB transfer, called on a falling edge, returns on a falling edge
    task automatic apb_xfer(input logic wr, input logic [15:0] addr,
                            input logic [7:0] wdata, output logic [7:0] rdata,
                            output logic err, output int lat);
        int   n;
        logic done;
        n         = 0;
        done      = 1'b0;
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = wr;
        paddr_i   = addr;
        pwdata_i  = wdata;
        while (!done) begin
            @(negedge clk16_i);
            n++;
            penable_i = 1'b1;
            if (pready_o) begin
                rdata = prdata_o;
                err   = pslverr_o;
                done  = 1'b1;
            end else if (n > 40) begin
                stop_on_timeout("pready_o");
            end
        end
        lat = n;
        @(negedge clk16_i);
        psel_i    = 1'b0;
        penable_i = 1'b0;
    endtask

    // in-range write, model follows on success
    task automatic apb_write(input string name, input logic [9:0] addr, input logic [7:0] d);
        logic [7:0] rd;
        logic       err;
        int         lat;
        apb_xfer(1'b1, {6'd0, addr}, d, rd, err, lat);
        check_value({name, " pslverr"}, 16'd0, {15'd0, err});
        check_true(name, lat <= 19, "write took longer than 19 cycles");
        model[addr] = d;
        known[addr] = 1'b1;
    endtask

    task automatic apb_read_check(input string name, input logic [9:0] addr);
        logic [7:0] rd;
        logic       err;
        int         lat;
        apb_xfer(1'b0, {6'd0, addr}, 8'h00, rd, err, lat);
        check_value({name, " pslverr"}, 16'd0, {15'd0, err});
        check_true(name, lat <= 19, "read took longer than 19 cycles");
        check_value(name, {8'd0, model[addr]}, {8'd0, rd});
    endtask

    // present a cpu request until its slot 7 access has passed
    task automatic cpu_access(input logic wr, input logic [9:0] addr, input logic [7:0] d);
        int n;
        n         = 0;
        cpu_req_i = '{valid: 1'b1, write: wr, addr: addr, wdata: d};
        while (!cpu_clk_o) begin
            @(negedge clk16_i);
            n++;
            if (n > 40) begin
                stop_on_timeout("cpu_clk_o");
            end
        end
        // write lands at the edge that ends this pulse
        if (wr) begin
            model[addr] = d;
            known[addr] = 1'b1;
        end
        @(negedge clk16_i);
        cpu_req_i = '0;
    endtask

    // video stream monitor, runs for the whole test
    always @(negedge clk16_i) begin
        if (rst_n_i && video_o.valid) begin
            // one byte per frame, the cycle after the slot 1 access
            assert ((cyc % 16) == 4) else begin
                $display("FAIL video_valid: expected cycle 4, actual cycle %0d",
                         cyc % 16);
                video_errs++;
            end
            assert (video_o.addr === exp_vaddr) else begin
                $display("FAIL video_addr: expected %0h, actual %0h",
                         exp_vaddr, video_o.addr);
                video_errs++;
            end
            if (known[video_o.addr]) begin
                assert (video_o.data === model[video_o.addr]) else begin
                    $display("FAIL video_data: expected %0h, actual %0h",
                             model[video_o.addr], video_o.data);
                    video_errs++;
                end
                video_checked++;
            end
            exp_vaddr = `PET_VRAM_BASE
                      + 10'((exp_vaddr - `PET_VRAM_BASE + 1) % `PET_VRAM_CHARS);
        end
    end

    initial begin
        #2000000;
        $display("global timeout, simulation ran too long");
        $display("Verification failed");
        $finish;
    end

    initial begin
        logic [9:0]  addrs [0:11];
        logic [9:0]  a;
        logic [7:0]  d;
        logic [7:0]  rd;
        logic        err;
        int          lat;
        int          base_err;
        int          pulses;
        int          n;
        void'($urandom(32'h532f_714e));
        err_count     = 0;
        video_errs    = 0;
        video_checked = 0;
        exp_vaddr     = `PET_VRAM_BASE;
        for (int i = 0; i < (1 << `PET_RAM_AW); i++) begin
            known[i] = 1'b0;
            model[i] = 8'h00;
        end
        rst_n_i   = 1'b0;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
        paddr_i   = '0;
        pwdata_i  = '0;
        cpu_req_i = '0;
        repeat (2) @(posedge clk16_i);
        @(negedge clk16_i);

        // 1. outputs quiet in reset
        base_err = err_count;
        check_value("reset pready_o", 16'd0, {15'd0, pready_o});
        check_value("reset pslverr_o", 16'd0, {15'd0, pslverr_o});
        check_value("reset cpu_be_o", 16'd0, {15'd0, cpu_be_o});
        check_value("reset cpu_clk_o", 16'd0, {15'd0, cpu_clk_o});
        check_value("reset video valid", 16'd0, {15'd0, video_o.valid});
        report_test("reset_state", base_err);
        rst_n_i = 1'b1;

        // 2. cpu clock every 16 cycles at offset 15, inside bus enable
        base_err = err_count;
        pulses   = 0;
        repeat (48) begin
            @(negedge clk16_i);
            check_value("cpu_clk cadence", {15'd0, (cyc % 16) == 15}, {15'd0, cpu_clk_o});
            if (cpu_clk_o) begin
                pulses++;
                check_true("cpu_clk window", cpu_be_o, "cpu clock pulse without bus enable");
            end
        end
        check_value("cpu_clk pulses", 16'd3, 16'(pulses));
        report_test("cpu_clock_cadence", base_err);

        // 3. random writes then readback
        base_err = err_count;
        for (int i = 0; i < 12; i++) begin
            addrs[i] = 10'($urandom);
            apb_write("apb write", addrs[i], 8'($urandom));
        end
        for (int i = 0; i < 12; i++) begin
            apb_read_check("apb readback", addrs[i]);
        end
        report_test("apb_write_read", base_err);

        // 4. out of range accesses alias nothing
        base_err = err_count;
        for (int i = 0; i < 4; i++) begin
            a = addrs[i];
            apb_xfer(1'b1, 16'h0400 + 16'($urandom % 16'hfbff) | {6'd0, a}, 8'($urandom),
                     rd, err, lat);
            check_value("oor write pslverr", 16'd1, {15'd0, err});
            check_value("oor write latency", 16'd1, 16'(lat));
            apb_xfer(1'b0, 16'hfc00 | {6'd0, a}, 8'h00, rd, err, lat);
            check_value("oor read pslverr", 16'd1, {15'd0, err});
            apb_read_check("oor model intact", a);
        end
        report_test("apb_out_of_range", base_err);

        // 5. fill the screen, then watch a full scan of it
        base_err = err_count;
        for (int i = 0; i < `PET_VRAM_CHARS; i++) begin
            apb_write("screen fill", `PET_VRAM_BASE + 10'(i), 8'($urandom));
        end
        n             = 0;
        video_checked = 0;
        while (video_checked < `PET_VRAM_CHARS + 8) begin
            @(negedge clk16_i);
            n++;
            if (n > 16 * (`PET_VRAM_CHARS + 16)) begin
                stop_on_timeout("video bytes");
            end
            // overwrite a screen byte now and then during the scan
            if ((n % 100) == 0) begin
                apb_write("screen update", `PET_VRAM_BASE + 10'($urandom % 64), 8'($urandom));
            end
        end
        err_count = err_count + video_errs;
        video_errs = 0;
        report_test("video_stream", base_err);

        // 6. cpu writes seen by host, host writes seen by cpu
        base_err = err_count;
        for (int i = 0; i < 4; i++) begin
            a = 10'($urandom);
            cpu_access(1'b1, a, 8'($urandom));
            apb_read_check("cpu write readback", a);
            a = 10'($urandom);
            d = 8'($urandom);
            apb_write("host write for cpu", a, d);
            cpu_access(1'b0, a, 8'h00);
            check_value("cpu read", {8'd0, d}, {8'd0, cpu_rdata_o});
        end
        report_test("cpu_port", base_err);

        err_count = err_count + video_errs;
        $display("checks done, %0d errors", err_count);
        if (err_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+verilog
verilog/pet_bus_pkg.sv
verilog/bus_timing.sv
verilog/host_apb_port.sv
verilog/bus_arbiter_ram.sv
verilog/video_fetch.sv
verilog/pet_bus_top.sv
bench/pet_bus_chk.sv
bench/pet_bus_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the pet_bus testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f --top-module pet_bus_tb -o Vpet_bus_tb
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

out=$(./obj_dir/Vpet_bus_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "Verification passed"; then
    exit 0
fi
exit 1
